/* Bender.yml */
package:
  name: control_unit

sources:
  - rtl/cu_pkg.sv
  - rtl/dp_ctrl_if.sv
  - rtl/cycle_counter.sv
  - rtl/psw_reg.sv
  - rtl/cex_tracker.sv
  - rtl/cycle_sequencer.sv
  - rtl/control_unit.sv
  - target: simulation
    files:
      - verification/control_unit_tb.sv

/* control_unit.f */
rtl/cu_pkg.sv
rtl/dp_ctrl_if.sv
rtl/cycle_counter.sv
rtl/psw_reg.sv
rtl/cex_tracker.sv
rtl/cycle_sequencer.sv
rtl/control_unit.sv
verification/control_unit_tb.sv

/* rtl/cex_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module cex_tracker (
	input logic clock,
	input logic cpucycle_rst,
	input cu_pkg::word_t psw,
	input logic cex_load,
	input logic [3:0] cond,
	input logic [2:0] t_cnt,
	input logic [2:0] f_cnt,
	input logic decode,
	output logic allow
);
	import cu_pkg::*;

	logic active;        // CEX block in progress
	logic result;        // Condition at CEX time
	logic [2:0] t_left;  // Remaining true-side instructions
	logic [2:0] f_left;  // Remaining false-side instructions

	// True side runs first, then the false side
	always_comb
		allow = !active
			|| (result && (t_left != 3'd0))
			|| (!result && (t_left == 3'd0) && (f_left != 3'd0));

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
		begin
			active <= 1'b0;
			result <= 1'b0;
			t_left <= 3'd0;
			f_left <= 3'd0;
		end
		else if (cex_load)
		begin
			active <= (t_cnt != 3'd0) || (f_cnt != 3'd0); // Empty block never starts
			result <= cond_true(cond, psw);
			t_left <= t_cnt;
			f_left <= f_cnt;
		end
		else if (decode && active)
		begin
			if (t_left != 3'd0)
			begin
				t_left <= t_left - 3'd1;
				if ((t_left == 3'd1) && (f_left == 3'd0))
					active <= 1'b0;                   // Nothing left on either side
			end
			else if (f_left != 3'd0)
			begin
				f_left <= f_left - 3'd1;
				if (f_left == 3'd1)
					active <= 1'b0;
			end
		end
	end

	assert property (@(posedge clock) disable iff (cpucycle_rst) cex_load |-> !active);

endmodule

`default_nettype wire

/* rtl/control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit #(
	parameter int BRANCH_SIGN_BIT = 10,
	parameter int BL_SIGN_BIT = 13,
	parameter int LAST_CYCLE = 7
) (
	input logic clock,
	input logic cpucycle_rst,
	input cu_pkg::word_t pc,
	input cu_pkg::word_t brkpnt,
	input logic [6:0] op,
	input logic [2:0] dst,
	input logic [2:0] srccon,
	input logic wb,
	input logic rc,
	input logic [3:0] cond,
	input logic [2:0] t_cnt,
	input logic [2:0] f_cnt,
	input logic [2:0] pri,
	input logic [4:0] psw_bits,
	input cu_pkg::word_t psw_in,
	input logic psw_load,
	output logic dec_en,
	output logic halted,
	output cu_pkg::cycle_t cycle,
	output cu_pkg::word_t psw_out,
	output cu_pkg::bus_ctrl_t data_bus_ctrl,
	output cu_pkg::bus_ctrl_t addr_bus_ctrl,
	output cu_pkg::mem_ctrl_t mem_ctrl,
	output cu_pkg::rnum_t dbus_rnum_dst,
	output cu_pkg::rnum_t dbus_rnum_src,
	output cu_pkg::rnum_t alu_rnum_dst,
	output cu_pkg::rnum_t alu_rnum_src,
	output cu_pkg::rnum_t addr_rnum_src,
	output logic [5:0] alu_op,
	output logic psw_update,
	output logic s_bus_ctrl,
	output logic [4:0] sxt_bit_num,
	output logic sxt_shift,
	output logic sxt_bus_ctrl
);
	logic restart;
	logic hold;
	logic allow;
	logic cex_load;
	logic decode;
	logic cc_set;
	logic cc_clr;
	logic pri_set;

	dp_ctrl_if dp ();

	cycle_counter #(.LAST_CYCLE(LAST_CYCLE)) u_counter (.clock, .cpucycle_rst, .restart,
		.hold, .cycle);

	psw_reg u_psw (.clock, .cpucycle_rst, .psw_in, .psw_load, .cc_set, .cc_clr,
		.cc_bits(psw_bits), .pri_set, .new_pri(pri), .psw(psw_out));

	cex_tracker u_cex (.clock, .cpucycle_rst, .psw(psw_out), .cex_load, .cond, .t_cnt,
		.f_cnt, .decode, .allow);

	cycle_sequencer #(.BRANCH_SIGN_BIT(BRANCH_SIGN_BIT), .BL_SIGN_BIT(BL_SIGN_BIT)) u_seq (
		.clock, .cpucycle_rst, .cycle, .pc, .brkpnt, .psw(psw_out), .allow, .op, .dst,
		.srccon, .wb, .rc, .dec_en, .halted, .restart, .hold, .cex_load, .decode, .cc_set,
		.cc_clr, .pri_set, .dp(dp.issuer));

	assign data_bus_ctrl = dp.data_bus_ctrl;
	assign addr_bus_ctrl = dp.addr_bus_ctrl;
	assign mem_ctrl = dp.mem_ctrl;
	assign dbus_rnum_dst = dp.dbus_rnum_dst;
	assign dbus_rnum_src = dp.dbus_rnum_src;
	assign alu_rnum_dst = dp.alu_rnum_dst;
	assign alu_rnum_src = dp.alu_rnum_src;
	assign addr_rnum_src = dp.addr_rnum_src;
	assign alu_op = dp.alu_op;
	assign psw_update = dp.psw_update;
	assign s_bus_ctrl = dp.s_bus_ctrl;
	assign sxt_bit_num = dp.sxt_bit_num;
	assign sxt_shift = dp.sxt_shift;
	assign sxt_bus_ctrl = 1'b1;      // Sign extender always takes the decoded offset

endmodule

`default_nettype wire

/* rtl/cu_pkg.sv */
`default_nettype none

package cu_pkg;

	typedef logic [15:0] word_t;    // Data or address word
	typedef logic [3:0] cycle_t;    // Cycle number 1 to 7
	typedef logic [4:0] rnum_t;     // Register file selector
	typedef logic [6:0] bus_ctrl_t; // {byte, src[2:0], dst[2:0]}
	typedef logic [2:0] mem_ctrl_t; // {enable, write, byte}

	localparam rnum_t REG_LR = 5'd5;
	localparam rnum_t REG_PC = 5'd7;
	localparam rnum_t REG_TWO = 5'd10; // Constant 2 for the fetch increment

	// Source 0 MDR, 1 reg file, 3 ALU, 4 sign extender; dest 0 MDR or MAR, 1 reg file, 2 IR
	localparam bus_ctrl_t BUS_IDLE = 7'b1111111;
	localparam bus_ctrl_t BUS_PC_TO_MAR = 7'b0001000;  // Any reg, picked by addr_rnum_src
	localparam bus_ctrl_t BUS_ALU_TO_REG = 7'b0011001;
	localparam bus_ctrl_t BUS_REG_TO_REG = 7'b0001001;
	localparam bus_ctrl_t BUS_MDR_TO_IR = 7'b0000010;
	localparam bus_ctrl_t BUS_MDR_TO_REG = 7'b0000001;
	localparam bus_ctrl_t BUS_REG_TO_MDR = 7'b0001000;
	localparam bus_ctrl_t BUS_ALU_TO_MAR = 7'b0011000;

	localparam mem_ctrl_t MEM_IDLE = 3'b000;
	localparam mem_ctrl_t MEM_READ = 3'b100;
	localparam mem_ctrl_t MEM_WRITE = 3'b110; // Byte bit ORed in from WB

	localparam logic [6:0] OP_BL = 7'd0;
	localparam logic [6:0] OP_BEQ = 7'd1;
	localparam logic [6:0] OP_BRA = 7'd8;
	localparam logic [6:0] OP_ADD = 7'd9;
	localparam logic [6:0] OP_BIS = 7'd20;
	localparam logic [6:0] OP_MOV = 7'd21;
	localparam logic [6:0] OP_SRA = 7'd23;
	localparam logic [6:0] OP_RRC = 7'd24;
	localparam logic [6:0] OP_SETPRI = 7'd28;
	localparam logic [6:0] OP_SETCC = 7'd30;
	localparam logic [6:0] OP_CLRCC = 7'd31;
	localparam logic [6:0] OP_CEX = 7'd32;
	localparam logic [6:0] OP_LD = 7'd33;
	localparam logic [6:0] OP_ST = 7'd34;
	localparam logic [6:0] OP_LDR = 7'd39;
	localparam logic [6:0] OP_STR = 7'd40;

	localparam int PSW_C = 0;
	localparam int PSW_Z = 1;
	localparam int PSW_N = 2;
	localparam int PSW_SLP = 3;
	localparam int PSW_V = 4;
	localparam int PSW_PRI_LO = 5;
	localparam int PSW_PRI_HI = 7;
	localparam int PSW_PPRI_LO = 13;
	localparam int PSW_PPRI_HI = 15;

	localparam word_t PSW_RESET = 16'h60e0;

	// Shared by CEX and the conditional branches
	function automatic logic cond_true(input logic [3:0] code, input word_t psw);
		logic c;
		logic z;
		logic n;
		logic v;
		c = psw[PSW_C];
		z = psw[PSW_Z];
		n = psw[PSW_N];
		v = psw[PSW_V];
		case (code)
			4'd0: return z;                 // EQ
			4'd1: return !z;                // NE
			4'd2: return c;                 // CS
			4'd3: return !c;                // CC
			4'd4: return n;                 // MI
			4'd5: return !n;                // PL
			4'd6: return v;                 // VS
			4'd7: return !v;                // VC
			4'd8: return c && !z;           // HI
			4'd9: return !c || z;           // LS
			4'd10: return n == v;           // GE
			4'd11: return n != v;           // LT
			4'd12: return !z && (n == v);   // GT
			4'd13: return z || (n != v);    // LE
			4'd14: return 1'b1;             // AL
			default: return 1'b0;
		endcase
	endfunction

endpackage

`default_nettype wire

/* rtl/cycle_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module cycle_counter #(
	parameter int LAST_CYCLE = 7
) (
	input logic clock,
	input logic cpucycle_rst,
	input logic restart,
	input logic hold,
	output cu_pkg::cycle_t cycle
);
	import cu_pkg::*;

	localparam logic [LAST_CYCLE-1:0] FIRST_STEP = 1;

	logic [LAST_CYCLE-1:0] step; // One bit per cycle

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst || restart)
			step <= FIRST_STEP;                 // Back to fetch
		else if (!hold)
		begin
			if (step[LAST_CYCLE-1])
				step <= FIRST_STEP;             // Wrap after the last execute step
			else
				step <= step << 1;
		end
	end

	always_comb
	begin
		cycle = cycle_t'(1);
		for (int i = 0; i < LAST_CYCLE; i++)
			if (step[i])
				cycle = cycle_t'(i + 1);        // Step bit to cycle number
	end

	assert property (@(posedge clock) disable iff (cpucycle_rst) $onehot(step));

endmodule

`default_nettype wire

/* rtl/cycle_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module cycle_sequencer #(
	parameter int BRANCH_SIGN_BIT = 10,
	parameter int BL_SIGN_BIT = 13
) (
	input logic clock,
	input logic cpucycle_rst,
	input cu_pkg::cycle_t cycle,
	input cu_pkg::word_t pc,
	input cu_pkg::word_t brkpnt,
	input cu_pkg::word_t psw,
	input logic allow,
	input logic [6:0] op,
	input logic [2:0] dst,
	input logic [2:0] srccon,
	input logic wb,
	input logic rc,
	output logic dec_en,
	output logic halted,
	output logic restart,
	output logic hold,
	output logic cex_load,
	output logic decode,
	output logic cc_set,
	output logic cc_clr,
	output logic pri_set,
	dp_ctrl_if.issuer dp
);
	import cu_pkg::*;

	localparam logic [4:0] LDR_SIGN_BIT = 5'd6; // Offset sign bit for LDR and STR

	logic run;
	logic at_brk;
	logic nx_halted;
	logic [6:0] op_q;      // Opcode kept for cycles 6 and 7
	logic wb_q;
	logic [6:0] alu_base;
	logic [3:0] br_code;
	bus_ctrl_t nx_data_bus;
	bus_ctrl_t nx_addr_bus;
	mem_ctrl_t nx_mem;
	rnum_t nx_dbus_dst;
	rnum_t nx_dbus_src;
	rnum_t nx_alu_dst;
	rnum_t nx_alu_src;
	rnum_t nx_addr_src;
	logic [5:0] nx_alu_op;
	logic nx_psw_update;
	logic nx_s_bus;
	logic [4:0] nx_sxt_bit;
	logic nx_sxt_shift;

	assign run = !psw[PSW_SLP];                  // Sleep freezes the whole sequence
	assign at_brk = (pc == brkpnt);
	assign decode = run && (cycle == 4'd4);
	assign dec_en = decode && allow;
	assign hold = !run || halted;
	assign nx_halted = (cycle == 4'd1) && at_brk;
	assign alu_base = (op >= OP_SRA) ? (op - 7'd11) : (op - OP_ADD); // SRA and RRC follow BIS
	// BEQ to BLT map onto EQ..MI, GE, LT; BRA is AL
	assign br_code = (op <= 7'd5) ? 4'(op - 7'd1) : (op == OP_BRA) ? 4'd14 : 4'(op + 7'd4);

	always_comb
	begin
		nx_data_bus = BUS_IDLE;
		nx_addr_bus = BUS_IDLE;
		nx_mem = MEM_IDLE;
		nx_psw_update = 1'b0;
		nx_dbus_dst = dp.dbus_rnum_dst;           // Selectors hold between words
		nx_dbus_src = dp.dbus_rnum_src;
		nx_alu_dst = dp.alu_rnum_dst;
		nx_alu_src = dp.alu_rnum_src;
		nx_addr_src = dp.addr_rnum_src;
		nx_alu_op = dp.alu_op;
		nx_s_bus = dp.s_bus_ctrl;
		nx_sxt_bit = dp.sxt_bit_num;
		nx_sxt_shift = dp.sxt_shift;
		restart = 1'b0;
		cex_load = 1'b0;
		cc_set = 1'b0;
		cc_clr = 1'b0;
		pri_set = 1'b0;
		if (run)
		begin
			case (cycle)
				4'd1:
					if (at_brk)
						restart = 1'b1;               // Park in fetch
					else if (!halted)
					begin
						nx_dbus_dst = REG_PC;
						nx_alu_dst = REG_PC;
						nx_alu_src = REG_TWO;         // PC plus 2
						nx_s_bus = 1'b0;
						nx_alu_op = 6'd0;
						nx_addr_src = REG_PC;
						nx_addr_bus = BUS_PC_TO_MAR;
						nx_mem = MEM_READ;
					end
				4'd2: nx_data_bus = BUS_ALU_TO_REG;   // Incremented PC back
				4'd3: nx_data_bus = BUS_MDR_TO_IR;
				4'd4:
					if (!allow)
						restart = 1'b1;               // CEX skip
				4'd5:
					case (op) inside
						OP_BL:
						begin
							nx_dbus_dst = REG_LR;
							nx_dbus_src = REG_PC;
							nx_data_bus = BUS_REG_TO_REG;  // Return address into LR
							nx_sxt_bit = 5'(BL_SIGN_BIT);
							nx_sxt_shift = 1'b1;
							nx_s_bus = 1'b1;
							nx_alu_op = 6'd0;
							nx_alu_dst = REG_PC;          // PC plus offset, written in cycle 6
						end
						[OP_BEQ:OP_BRA]:
						begin
							if (cond_true(br_code, psw))
							begin
								nx_s_bus = 1'b1;
								nx_sxt_bit = 5'(BRANCH_SIGN_BIT);
								nx_sxt_shift = 1'b1;
								nx_alu_op = 6'd0;
								nx_alu_dst = REG_PC;
								nx_dbus_dst = REG_PC;
								nx_data_bus = BUS_ALU_TO_REG;
							end
							restart = 1'b1;
						end
						[OP_ADD:OP_BIS], [OP_SRA:OP_RRC]:
						begin
							nx_alu_dst = {2'b00, dst};
							nx_alu_src = {1'b0, rc, srccon};   // rc picks the constant bank
							nx_dbus_dst = {2'b00, dst};
							nx_psw_update = 1'b1;
							nx_s_bus = 1'b0;
							nx_alu_op = {alu_base[4:0], wb};
							nx_data_bus = {wb, BUS_ALU_TO_REG[5:0]};
							restart = 1'b1;
						end
						OP_MOV:
						begin
							nx_dbus_dst = {2'b00, dst};
							nx_dbus_src = {2'b00, srccon};
							nx_data_bus = {wb, BUS_REG_TO_REG[5:0]};
							restart = 1'b1;
						end
						OP_SETPRI:
						begin
							pri_set = 1'b1;
							restart = 1'b1;
						end
						OP_SETCC:
						begin
							cc_set = 1'b1;
							restart = 1'b1;
						end
						OP_CLRCC:
						begin
							cc_clr = 1'b1;
							restart = 1'b1;
						end
						OP_CEX:
						begin
							cex_load = 1'b1;
							restart = 1'b1;
						end
						OP_LD, OP_ST:
						begin
							nx_dbus_dst = {2'b00, dst};       // LD target
							nx_dbus_src = {2'b00, srccon};    // ST data
							nx_addr_src = (op == OP_LD) ? {2'b00, srccon} : {2'b00, dst};
							nx_addr_bus = BUS_PC_TO_MAR;
						end
						OP_LDR, OP_STR:
						begin
							nx_sxt_bit = LDR_SIGN_BIT;
							nx_sxt_shift = 1'b0;
							nx_s_bus = 1'b1;
							nx_alu_op = 6'd0;                 // Base plus offset
							nx_alu_dst = (op == OP_LDR) ? {2'b00, srccon} : {2'b00, dst};
							nx_dbus_dst = {2'b00, dst};
							nx_dbus_src = {2'b00, srccon};
							nx_addr_bus = BUS_ALU_TO_MAR;
						end
						default: restart = 1'b1;
					endcase
				4'd6:
					case (op_q)
						OP_BL:
						begin
							nx_dbus_dst = REG_PC;
							nx_data_bus = BUS_ALU_TO_REG;
							restart = 1'b1;
						end
						OP_LD, OP_LDR: nx_mem = MEM_READ;
						OP_ST, OP_STR: nx_data_bus = {wb_q, BUS_REG_TO_MDR[5:0]};
						default: restart = 1'b1;
					endcase
				4'd7:
				begin
					if ((op_q == OP_LD) || (op_q == OP_LDR))
						nx_data_bus = {wb_q, BUS_MDR_TO_REG[5:0]};
					else if ((op_q == OP_ST) || (op_q == OP_STR))
						nx_mem = MEM_WRITE | {2'b00, wb_q};
					restart = 1'b1;
				end
				default: restart = 1'b1;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (run && (cycle == 4'd5))
		begin
			op_q <= op;                               // Decoder fields are gone after cycle 5
			wb_q <= wb;
		end
	end

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
		begin
			dp.data_bus_ctrl <= BUS_IDLE;
			dp.addr_bus_ctrl <= BUS_IDLE;
			dp.mem_ctrl <= MEM_IDLE;
			dp.psw_update <= 1'b0;
			dp.dbus_rnum_dst <= '0;
			dp.dbus_rnum_src <= '0;
			dp.alu_rnum_dst <= '0;
			dp.alu_rnum_src <= '0;
			dp.addr_rnum_src <= '0;
			dp.alu_op <= '0;
			dp.s_bus_ctrl <= 1'b0;
			dp.sxt_bit_num <= '0;
			dp.sxt_shift <= 1'b0;
			halted <= 1'b0;
		end
		else
		begin
			dp.data_bus_ctrl <= nx_data_bus;
			dp.addr_bus_ctrl <= nx_addr_bus;
			dp.mem_ctrl <= nx_mem;
			dp.psw_update <= nx_psw_update;
			dp.dbus_rnum_dst <= nx_dbus_dst;
			dp.dbus_rnum_src <= nx_dbus_src;
			dp.alu_rnum_dst <= nx_alu_dst;
			dp.alu_rnum_src <= nx_alu_src;
			dp.addr_rnum_src <= nx_addr_src;
			dp.alu_op <= nx_alu_op;
			dp.s_bus_ctrl <= nx_s_bus;
			dp.sxt_bit_num <= nx_sxt_bit;
			dp.sxt_shift <= nx_sxt_shift;
			halted <= nx_halted;
		end
	end

	// Fetch cycles only end early at a breakpoint
	assert property (@(posedge clock) disable iff (cpucycle_rst)
		(restart && (cycle inside {[4'd1:4'd3]})) |-> ((cycle == 4'd1) && at_brk));

endmodule

`default_nettype wire

/* rtl/dp_ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface dp_ctrl_if;
	import cu_pkg::*;

	bus_ctrl_t data_bus_ctrl;
	bus_ctrl_t addr_bus_ctrl;
	mem_ctrl_t mem_ctrl;
	rnum_t dbus_rnum_dst;
	rnum_t dbus_rnum_src;
	rnum_t alu_rnum_dst;    // ALU A operand and result register
	rnum_t alu_rnum_src;    // ALU B operand when the S-bus takes the reg file
	rnum_t addr_rnum_src;
	logic [5:0] alu_op;     // {operation, byte}
	logic psw_update;       // ALU writes flags
	logic s_bus_ctrl;       // 0 reg file, 1 sign extender
	logic [4:0] sxt_bit_num;
	logic sxt_shift;        // Offset shifted left by one

	modport issuer (output data_bus_ctrl, addr_bus_ctrl, mem_ctrl, dbus_rnum_dst,
		dbus_rnum_src, alu_rnum_dst, alu_rnum_src, addr_rnum_src, alu_op, psw_update,
		s_bus_ctrl, sxt_bit_num, sxt_shift);

	modport sink (input data_bus_ctrl, addr_bus_ctrl, mem_ctrl, dbus_rnum_dst,
		dbus_rnum_src, alu_rnum_dst, alu_rnum_src, addr_rnum_src, alu_op, psw_update,
		s_bus_ctrl, sxt_bit_num, sxt_shift);

endinterface

`default_nettype wire

/* rtl/psw_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module psw_reg (
	input logic clock,
	input logic cpucycle_rst,
	input cu_pkg::word_t psw_in,
	input logic psw_load,
	input logic cc_set,
	input logic cc_clr,
	input logic [4:0] cc_bits,
	input logic pri_set,
	input logic [2:0] new_pri,
	output cu_pkg::word_t psw
);
	import cu_pkg::*;

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
			psw <= PSW_RESET;
		else if (psw_load)
			psw <= psw_in;                                  // ALU result wins over SETCC and friends
		else
		begin
			if (cc_set)
				psw[PSW_V:PSW_C] <= psw[PSW_V:PSW_C] | cc_bits;
			else if (cc_clr)
				psw[PSW_V:PSW_C] <= psw[PSW_V:PSW_C] & ~cc_bits;
			// Priority may only drop and a raise is ignored
			if (pri_set && (new_pri < psw[PSW_PRI_HI:PSW_PRI_LO]))
				psw[PSW_PRI_HI:PSW_PRI_LO] <= new_pri;
		end
	end

	assert property (@(posedge clock) disable iff (cpucycle_rst) !(cc_set && cc_clr));

endmodule

`default_nettype wire

/* verification/control_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit_tb;
	import cu_pkg::*;

	typedef struct {
		string name;
		logic [6:0] op;
		logic [2:0] dst;
		logic [2:0] srccon;
		logic wb;
		logic [3:0] cond;
		logic [2:0] t_cnt;
		logic [2:0] f_cnt;
		logic [2:0] pri;
		logic [4:0] bits;
		int psw_mode;        // 0 keep, 1 load psw_val, 2 load random flags
		word_t psw_val;
		int exp_len;         // Cycles from fetch to fetch
	} row_t;

	logic clock;
	logic cpucycle_rst;
	word_t pc;
	word_t brkpnt;
	logic [6:0] op;
	logic [2:0] dst;
	logic [2:0] srccon;
	logic wb;
	logic rc;
	logic [3:0] cond;
	logic [2:0] t_cnt;
	logic [2:0] f_cnt;
	logic [2:0] pri;
	logic [4:0] psw_bits;
	word_t psw_in;
	logic psw_load;
	logic dec_en;
	logic halted;
	cycle_t cycle;
	word_t psw_out;
	bus_ctrl_t data_bus_ctrl;
	bus_ctrl_t addr_bus_ctrl;
	mem_ctrl_t mem_ctrl;
	rnum_t dbus_rnum_dst;
	rnum_t dbus_rnum_src;
	rnum_t alu_rnum_dst;
	rnum_t alu_rnum_src;
	rnum_t addr_rnum_src;
	logic [5:0] alu_op;
	logic psw_update;
	logic s_bus_ctrl;
	logic [4:0] sxt_bit_num;
	logic sxt_shift;
	logic sxt_bus_ctrl;

	row_t rows[$];
	int errors = 0;
	int cyc_count = 0;
	int limit = 100000;           // Replaced once the table is built
	integer seed = 32'hdd6c;
	word_t model_psw;             // Expected PSW
	logic cx_act;                 // Expected CEX state
	logic cx_res;
	logic [2:0] cx_t;
	logic [2:0] cx_f;
	bus_ctrl_t w_data[1:7];       // Control words, indexed by the cycle that made them
	bus_ctrl_t w_abus[1:7];
	mem_ctrl_t w_mem[1:7];
	rnum_t w_dst[1:7];
	rnum_t w_src[1:7];
	rnum_t w_adst[1:7];
	rnum_t w_asrc[1:7];
	rnum_t w_addr[1:7];
	logic [5:0] w_aluop[1:7];
	logic w_pswu[1:7];
	logic [6:0] w_sxt[1:7];       // {s_bus_ctrl, sxt_shift, sxt_bit_num}

	control_unit DUT (.*);

	initial
	begin
		clock = 1'b0;
		forever
			#5 clock = ~clock;
	end

	always @(posedge clock)
	begin
		cyc_count++;
		if (cyc_count >= limit)
		begin
			$display("Run timed out after %0d cycles", cyc_count);
			$display("** FAIL **");
			$finish;
		end
	end

	// Condition table as pairs of rule and inverse, then AL and never
	function automatic logic cond_ok(input logic [3:0] code, input word_t p);
		logic r;
		case (code[3:1])
			3'd0: r = p[1];
			3'd1: r = p[0];
			3'd2: r = p[2];
			3'd3: r = p[4];
			3'd4: r = p[0] & ~p[1];                 // HI, LS inverts
			3'd5: r = ~(p[2] ^ p[4]);               // GE, LT inverts
			3'd6: r = ~p[1] & ~(p[2] ^ p[4]);       // GT, LE inverts
			default: r = 1'b1;
		endcase
		if (code == 4'd15)
			return 1'b0;
		if (code == 4'd14)
			return 1'b1;
		return code[0] ? ~r : r;
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
		begin
			$display("FAIL %s: expected %0h, actual %0h", name, exp, act);
			errors++;
		end
	endtask

	task automatic add_row(input string name, input logic [6:0] o, input logic [2:0] d,
		input logic [2:0] s, input logic w, input logic [3:0] c, input logic [2:0] t,
		input logic [2:0] f, input logic [2:0] p, input logic [4:0] b, input int mode,
		input word_t val, input int len);
		row_t r;
		r = '{name, o, d, s, w, c, t, f, p, b, mode, val, len};
		rows.push_back(r);
	endtask

	task automatic run_row(input row_t r);
		int len;
		cycle_t prev;
		logic seen;
		logic ok;
		logic [3:0] code;
		logic [3:0] br_map[1:8];
		br_map = '{4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd10, 4'd11, 4'd14}; // BEQ..BRA
		if (r.psw_mode == 1)
			psw_in = r.psw_val;
		else if (r.psw_mode == 2)
			psw_in = (word_t'($random(seed)) & 16'h0017) | 16'h60e0; // Flags only, no sleep
		psw_load = (r.psw_mode != 0);
		if (psw_load)
			model_psw = psw_in;
		ok = !cx_act || (cx_res && cx_t != 0) || (!cx_res && cx_t == 0 && cx_f != 0);
		if (cx_act)
		begin
			if (cx_t != 0)
				cx_t--;
			else if (cx_f != 0)
				cx_f--;
			cx_act = (cx_t != 0) || (cx_f != 0);
		end
		for (int i = 1; i <= 7; i++)
		begin
			w_data[i] = BUS_IDLE;
			w_mem[i] = MEM_IDLE;
		end
		len = 0;
		seen = 1'b0;
		prev = cycle;
		do
		begin
			@(posedge clock);
			#1;
			psw_load = 1'b0;
			len++;
			w_data[prev] = data_bus_ctrl;                // Word made in the previous cycle
			w_abus[prev] = addr_bus_ctrl;
			w_mem[prev] = mem_ctrl;
			w_dst[prev] = dbus_rnum_dst;
			w_src[prev] = dbus_rnum_src;
			w_adst[prev] = alu_rnum_dst;
			w_asrc[prev] = alu_rnum_src;
			w_addr[prev] = addr_rnum_src;
			w_aluop[prev] = alu_op;
			w_pswu[prev] = psw_update;
			w_sxt[prev] = {s_bus_ctrl, sxt_shift, sxt_bit_num};
			if (cycle == 4'd4 && dec_en)
			begin
				seen = 1'b1;
				op = r.op;                               // Decoder answer
				dst = r.dst;
				srccon = r.srccon;
				wb = r.wb;
				cond = r.cond;
				t_cnt = r.t_cnt;
				f_cnt = r.f_cnt;
				pri = r.pri;
				psw_bits = r.bits;
			end
			prev = cycle;
		end
		while (cycle != 4'd1 && len < 12);
		check_val({r.name, " dec_en"}, ok, seen);
		check_val({r.name, " length"}, r.exp_len, len);
		check_val({r.name, " fetch addr_bus_ctrl"}, BUS_PC_TO_MAR, w_abus[1]);
		check_val({r.name, " fetch addr_rnum_src"}, 7, w_addr[1]);
		check_val({r.name, " fetch mem_ctrl"}, 3'b100, w_mem[1]);
		check_val({r.name, " fetch alu_rnum_dst"}, 7, w_adst[1]);
		check_val({r.name, " fetch alu_rnum_src"}, 10, w_asrc[1]);  // Constant 2
		check_val({r.name, " pc write-back"}, BUS_ALU_TO_REG, w_data[2]);
		check_val({r.name, " ir load"}, BUS_MDR_TO_IR, w_data[3]);
		if (!ok)
			return;
		if (r.op == OP_CEX)
		begin
			cx_act = (r.t_cnt != 0) || (r.f_cnt != 0);
			cx_res = cond_ok(r.cond, model_psw);
			cx_t = r.t_cnt;
			cx_f = r.f_cnt;
		end
		else if ((r.op >= OP_ADD && r.op <= OP_BIS) || r.op == OP_SRA || r.op == OP_RRC)
		begin
			check_val({r.name, " alu_op"},
				(r.op >= OP_SRA) ? 2 * (r.op - 11) + r.wb : 2 * (r.op - 9) + r.wb, w_aluop[5]);
			check_val({r.name, " dbus_rnum_dst"}, r.dst, w_dst[5]);
			check_val({r.name, " psw_update"}, 1, w_pswu[5]);
			check_val({r.name, " data_bus_ctrl"}, {r.wb, BUS_ALU_TO_REG[5:0]}, w_data[5]);
			check_val({r.name, " alu_rnum_dst"}, r.dst, w_adst[5]);
			check_val({r.name, " alu_rnum_src"}, {1'b0, rc, r.srccon}, w_asrc[5]);
			check_val({r.name, " s_bus_ctrl"}, 0, w_sxt[5][6]);
		end
		else if (r.op >= OP_BEQ && r.op <= OP_BRA)
		begin
			code = br_map[r.op];
			check_val({r.name, " data_bus_ctrl"},
				cond_ok(code, model_psw) ? BUS_ALU_TO_REG : BUS_IDLE, w_data[5]);
			if (cond_ok(code, model_psw))
			begin
				check_val({r.name, " pc write"}, 7, w_dst[5]);
				check_val({r.name, " alu_rnum_dst"}, 7, w_adst[5]);
				check_val({r.name, " offset"}, {2'b11, 5'd10}, w_sxt[5]); // Sign bit 10
			end
		end
		else if (r.op == OP_BL)
		begin
			check_val({r.name, " lr bus"}, BUS_REG_TO_REG, w_data[5]);
			check_val({r.name, " lr dst"}, 5, w_dst[5]);
			check_val({r.name, " lr src"}, 7, w_src[5]);
			check_val({r.name, " offset"}, {2'b11, 5'd13}, w_sxt[5]);     // Sign bit 13
			check_val({r.name, " pc bus"}, BUS_ALU_TO_REG, w_data[6]);
			check_val({r.name, " pc dst"}, 7, w_dst[6]);
		end
		else if (r.op == OP_MOV)
		begin
			check_val({r.name, " data_bus_ctrl"}, {r.wb, BUS_REG_TO_REG[5:0]}, w_data[5]);
			check_val({r.name, " dbus_rnum_dst"}, r.dst, w_dst[5]);
			check_val({r.name, " dbus_rnum_src"}, r.srccon, w_src[5]);
		end
		else if (r.op == OP_LD || r.op == OP_LDR)
		begin
			check_val({r.name, " mem_ctrl"}, 3'b100, w_mem[6]);   // Read
			check_val({r.name, " load bus"}, {r.wb, BUS_MDR_TO_REG[5:0]}, w_data[7]);
		end
		else if (r.op == OP_ST || r.op == OP_STR)
		begin
			check_val({r.name, " mem_ctrl"}, {2'b11, r.wb}, w_mem[7]);
			check_val({r.name, " store bus"}, {r.wb, BUS_REG_TO_MDR[5:0]}, w_data[6]);
		end
		else if (r.op == OP_SETCC || r.op == OP_CLRCC || r.op == OP_SETPRI)
		begin
			if (r.op == OP_SETCC)
				model_psw[4:0] = model_psw[4:0] | r.bits;
			else if (r.op == OP_CLRCC)
				model_psw[4:0] = model_psw[4:0] & ~r.bits;
			else if (r.pri < model_psw[7:5])
				model_psw[7:5] = r.pri;                          // Lower only
			check_val({r.name, " psw_out"}, model_psw, psw_out);
		end
	endtask

	initial
	begin
		word_t cex_psw;
		logic cex_hit;
		cpucycle_rst = 1'b1;
		pc = 16'h0100;
		brkpnt = 16'hffff;
		op = '0;
		dst = '0;
		srccon = '0;
		wb = 1'b0;
		rc = 1'b0;
		cond = '0;
		t_cnt = '0;
		f_cnt = '0;
		pri = '0;
		psw_bits = '0;
		psw_in = '0;
		psw_load = 1'b0;
		cx_act = 1'b0;
		cx_res = 1'b0;
		cx_t = '0;
		cx_f = '0;
		add_row("add", OP_ADD, 3'd1, 3'd2, 1'b0, 0, 0, 0, 0, 0, 0, 0, 5);
		add_row("sub_b", 7'd10, 3'd3, 3'd4, 1'b1, 0, 0, 0, 0, 0, 0, 0, 5);
		add_row("bis", OP_BIS, 3'd6, 3'd0, 1'b0, 0, 0, 0, 0, 0, 0, 0, 5);
		add_row("sra", OP_SRA, 3'd2, 3'd0, 1'b1, 0, 0, 0, 0, 0, 0, 0, 5);
		add_row("rrc", OP_RRC, 3'd5, 3'd0, 1'b0, 0, 0, 0, 0, 0, 0, 0, 5);
		add_row("mov", OP_MOV, 3'd1, 3'd3, 1'b0, 0, 0, 0, 0, 0, 0, 0, 5);
		for (int b = 1; b <= 8; b++)
			add_row($sformatf("branch_%0d", b), 7'(b), 0, 0, 0, 0, 0, 0, 0, 0, 2, 0, 5);
		add_row("beq_taken", OP_BEQ, 0, 0, 0, 0, 0, 0, 0, 0, 1, 16'h60e2, 5);
		add_row("bl", OP_BL, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 6);
		add_row("setcc", OP_SETCC, 0, 0, 0, 0, 0, 0, 0, 5'b10101, 1, 16'h60e0, 5);
		add_row("clrcc", OP_CLRCC, 0, 0, 0, 0, 0, 0, 0, 5'b00101, 0, 0, 5);
		add_row("setpri_low", OP_SETPRI, 0, 0, 0, 0, 0, 0, 3'd3, 0, 0, 0, 5);
		add_row("setpri_high", OP_SETPRI, 0, 0, 0, 0, 0, 0, 3'd5, 0, 0, 0, 5);
		add_row("cex_al", OP_CEX, 0, 0, 0, 4'd14, 3'd2, 3'd1, 0, 0, 0, 0, 5);
		add_row("cex_t1", OP_ADD, 3'd1, 3'd1, 0, 0, 0, 0, 0, 0, 0, 0, 5);
		add_row("cex_t2", OP_MOV, 3'd2, 3'd1, 0, 0, 0, 0, 0, 0, 0, 0, 5);
		add_row("cex_f1_skip", OP_ADD, 3'd3, 3'd1, 0, 0, 0, 0, 0, 0, 0, 0, 4);
		add_row("cex_never", OP_CEX, 0, 0, 0, 4'd15, 3'd1, 3'd2, 0, 0, 0, 0, 5);
		add_row("cex_t1_skip", OP_ADD, 3'd1, 3'd2, 0, 0, 0, 0, 0, 0, 0, 0, 4);
		add_row("cex_f1", 7'd10, 3'd4, 3'd2, 1'b1, 0, 0, 0, 0, 0, 0, 0, 5);
		add_row("cex_f2", OP_MOV, 3'd4, 3'd1, 0, 0, 0, 0, 0, 0, 0, 0, 5);
		// One true-side and one false-side instruction per condition code
		for (int c = 0; c <= 13; c++)
		begin
			cex_psw = (word_t'($random(seed)) & 16'h0017) | 16'h60e0;
			cex_hit = cond_ok(4'(c), cex_psw);
			add_row($sformatf("cex_cond_%0d", c), OP_CEX, 0, 0, 0, 4'(c), 3'd1, 3'd1, 0, 0,
				1, cex_psw, 5);
			add_row($sformatf("cex_cond_%0d_t", c), OP_ADD, 3'd2, 3'd3, 0, 0, 0, 0, 0, 0,
				0, 0, cex_hit ? 5 : 4);
			add_row($sformatf("cex_cond_%0d_f", c), OP_MOV, 3'd4, 3'd5, 0, 0, 0, 0, 0, 0,
				0, 0, cex_hit ? 4 : 5);
		end
		add_row("ld", OP_LD, 3'd1, 3'd2, 1'b0, 0, 0, 0, 0, 0, 0, 0, 7);
		add_row("st", OP_ST, 3'd1, 3'd2, 1'b1, 0, 0, 0, 0, 0, 0, 0, 7);
		add_row("ldr", OP_LDR, 3'd3, 3'd4, 1'b1, 0, 0, 0, 0, 0, 0, 0, 7);
		add_row("str", OP_STR, 3'd3, 3'd4, 1'b0, 0, 0, 0, 0, 0, 0, 0, 7);
		limit = 8 * rows.size() * 7 + 50;
		repeat (2)
			@(posedge clock);
		#1;
		cpucycle_rst = 1'b0;
		model_psw = PSW_RESET;
		check_val("reset cycle", 1, cycle);
		check_val("reset data_bus_ctrl", BUS_IDLE, data_bus_ctrl);
		check_val("reset addr_bus_ctrl", BUS_IDLE, addr_bus_ctrl);
		check_val("reset mem_ctrl", 0, mem_ctrl);
		check_val("reset dec_en", 0, dec_en);
		check_val("reset psw_update", 0, psw_update);
		check_val("reset halted", 0, halted);
		check_val("reset psw_out", 16'h60e0, psw_out);
		check_val("reset sxt_bus_ctrl", 1, sxt_bus_ctrl);     // Offset selected
		foreach (rows[i])
			run_row(rows[i]);
		brkpnt = pc;                                       // Stop at the next fetch
		repeat (3)
		begin
			@(posedge clock);
			#1;
			check_val("brk halted", 1, halted);
			check_val("brk cycle", 1, cycle);
		end
		pc = pc + 16'd2;
		@(posedge clock);
		#1;
		check_val("brk release halted", 0, halted);
		check_val("brk release cycle", 1, cycle);
		@(posedge clock);
		#1;
		check_val("brk resume cycle", 2, cycle);
		$display("Checks done, %0d errors", errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire
